// File: testbench/bus_vectors.txt
# snp snp_addr kind size addr wdata exp_rdata exp_done name (hex except name)
# kind 0 read 1 write 2 lr 3 sc; size 0 byte 1 half 2 word; done bits buserr exc write done
0 00000000 1 2 00000100 11223344 00000000 3 wr_word
0 00000000 0 2 00000100 00000000 11223344 1 rd_word
0 00000000 1 1 00000102 beef0000 00000000 3 wr_half_hi
0 00000000 0 2 00000100 00000000 beef3344 1 rd_half_merge
0 00000000 1 1 00000101 55555555 00000000 5 mis_half_wr
0 00000000 0 2 00000102 00000000 00000000 5 mis_word_rd
0 00000000 0 1 00000103 00000000 00000000 5 mis_half_rd
0 00000000 1 2 00000106 66666666 00000000 5 mis_word_wr
0 00000000 0 2 00000100 00000000 beef3344 1 rd_after_mis
0 00000000 0 2 f0000000 00000000 00000000 9 err_rd
0 00000000 1 2 f0000010 deadbeef 00000000 b err_wr
0 00000000 1 2 00000200 00000005 00000000 3 wr_resv_init
0 00000000 2 2 00000200 00000000 00000005 1 lr_a
0 00000000 3 2 00000200 000000aa 00000000 3 sc_ok
0 00000000 0 2 00000200 00000000 000000aa 1 rd_sc_ok
0 00000000 3 2 00000200 000000bb 00000001 1 sc_no_resv
0 00000000 0 2 00000200 00000000 000000aa 1 rd_sc_fail
0 00000000 2 2 00000200 00000000 000000aa 1 lr_b
1 00000202 3 2 00000200 000000cc 00000001 1 sc_after_snoop
0 00000000 0 2 00000200 00000000 000000aa 1 rd_after_snoop
0 00000000 2 2 00000200 00000000 000000aa 1 lr_c
1 00000204 3 2 00000200 000000dd 00000000 3 sc_snoop_other
0 00000000 0 2 00000200 00000000 000000dd 1 rd_snoop_other
0 00000000 2 2 00000200 00000000 000000dd 1 lr_d
0 00000000 3 2 00000204 000000ee 00000001 1 sc_other_granule
0 00000000 1 2 00000300 a0a0a0a0 00000000 3 b2b_wr0
0 00000000 1 2 00000304 b1b1b1b1 00000000 3 b2b_wr1
0 00000000 1 2 00000308 c2c2c2c2 00000000 3 b2b_wr2
0 00000000 1 2 0000030c d3d3d3d3 00000000 3 b2b_wr3
0 00000000 1 0 0000030d 0000ee00 00000000 3 b2b_wr_byte
0 00000000 0 2 00000300 00000000 a0a0a0a0 1 b2b_rd0
0 00000000 0 2 0000030c 00000000 d3d3eed3 1 b2b_rd3
0 00000000 0 1 00000301 00000000 00000000 5 b2b_mis
0 00000000 0 2 00000304 00000000 b1b1b1b1 1 b2b_rd1
0 00000000 0 2 00000308 00000000 c2c2c2c2 1 b2b_rd2

// File: sources.f
rtl/bus_pkg.sv
rtl/bus_cmd_stage.sv
rtl/lrsc_monitor.sv
rtl/ahb_addr_phase.sv
rtl/ahb_data_phase.sv
rtl/hart_bus_port.sv
testbench/tb_clock_gen.sv
testbench/tb_hart_bus_port.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the hart bus port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_hart_bus_port \
    -f sources.f \
    -o sim_hart_bus_port

# A $fatal in the testbench gives a failing exit status
./obj_dir/sim_hart_bus_port

// File: testbench/tb_hart_bus_port.sv
/* Hart bus port testbench */
module tb_hart_bus_port;

    localparam int          TIMEOUT   = 50;  // Cycles allowed per wait
    localparam int unsigned RAND_SEED = 61957;
    localparam string       VEC_FILE  = "testbench/bus_vectors.txt";

    typedef struct packed {
        bus_pkg::data_t     rdata;
        bus_pkg::bus_done_t done;
        logic               cmp_rdata;  // Read data is defined for this command
    } expect_t;

    logic                clk;
    logic                rst;
    bus_pkg::bus_cmd_t   cmd;
    logic                ack;
    bus_pkg::bus_done_t  done;
    bus_pkg::data_t      rdata;
    bus_pkg::ahb_m_req_t ahb_m;
    bus_pkg::ahb_m_rsp_t ahb_rsp = '{hreadyout: 1'b1, hrdata: '0, hresp: 1'b0};
    bus_pkg::ahb_snoop_t snoop;

    expect_t        exp_q[$];       // Completions in command order
    string          exp_name_q[$];
    bus_pkg::addr_t haddr_q[$];     // Address phases still to come
    string          haddr_name_q[$];
    expect_t        got_exp;
    string          got_name;

    // ------------------------------
    // Slave model state
    // ------------------------------
    bus_pkg::data_t mem [bus_pkg::addr_t];  // Keyed by word address
    int unsigned    wait_tab [256];         // Wait states per transfer
    logic [7:0]     wait_idx  = 8'd0;
    logic           dp_active = 1'b0;       // Data phase in progress
    logic           dp_write  = 1'b0;
    logic           dp_err    = 1'b0;
    logic [1:0]     dp_size   = 2'd0;
    bus_pkg::addr_t dp_addr   = '0;
    int unsigned    dp_stall  = 0;          // Low-ready cycles left
    logic           slave_ready;

    tb_clock_gen clk_gen (.clk(clk), .rst(rst));

    hart_bus_port #(
        .RESV_GRANULE_LOG2(2)
    ) dut0 (
        .clk(clk), .rst(rst),
        .cmd(cmd), .ack(ack), .done(done), .rdata(rdata),
        .ahb_m(ahb_m), .ahb_rsp(ahb_rsp), .snoop(snoop)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t exp,
                              input bus_pkg::data_t act);
        if (act !== exp)
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_done(input string name, input bus_pkg::bus_done_t exp,
                              input bus_pkg::bus_done_t act);
        if (act !== exp)
            abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic bus_pkg::data_t mem_read(input bus_pkg::addr_t a);
        bus_pkg::addr_t key;
        key = {a[31:2], 2'b00};
        if (mem.exists(key))
            return mem[key];
        return key ^ 32'h5A5A_5A5A;  // Unwritten words
    endfunction

    task automatic mem_write(input bus_pkg::addr_t a, input logic [1:0] size,
                             input bus_pkg::data_t wd);
        bus_pkg::data_t word;
        word = mem_read(a);
        for (int b = 0; b < 4; b++)
        begin
            if (size == 2'd2 || (size == 2'd1 && b[1] == a[1])
                || (size == 2'd0 && b[1:0] == a[1:0]))
                word[8*b +: 8] = wd[8*b +: 8];  // Active byte lanes only
        end
        mem[{a[31:2], 2'b00}] = word;
    endtask

    // ------------------------------
    // AHB slave model
    // ------------------------------
    always @(posedge clk)
    begin
        slave_ready = !dp_active || dp_stall == 0;
        if (rst)
        begin
            dp_active = 1'b0;
        end
        else
        begin
            if (dp_active && dp_stall == 0)
            begin
                if (dp_write && !dp_err)
                    mem_write(dp_addr, dp_size, ahb_m.hwdata);
                dp_active = 1'b0;                    // Final data cycle
            end
            else if (dp_active)
            begin
                dp_stall = dp_stall - 1;
            end
            if (slave_ready && ahb_m.hsel && ahb_m.htrans == bus_pkg::HTRANS_NONSEQ)
            begin
                if (haddr_q.size() == 0)
                    abort_run("AHB transfer seen with no bus command pending");
                check_data($sformatf("%s haddr", haddr_name_q.pop_front()),
                           haddr_q.pop_front(), ahb_m.haddr);
                dp_active = 1'b1;
                dp_addr   = ahb_m.haddr;
                dp_write  = ahb_m.hwrite;
                dp_size   = ahb_m.hsize[1:0];
                dp_err    = ahb_m.haddr >= 32'hF000_0000;  // Error range
                dp_stall  = wait_tab[wait_idx] + (dp_err ? 1 : 0);  // ERROR takes 2 cycles
                wait_idx  = wait_idx + 8'd1;
            end
        end
    end

    always @(negedge clk)
    begin
        ahb_rsp.hreadyout = !dp_active || dp_stall == 0;
        ahb_rsp.hresp     = dp_active && dp_err && dp_stall <= 1;
        ahb_rsp.hrdata    = (dp_active && !dp_write && !dp_err) ? mem_read(dp_addr) : '0;
    end

    // Completion checker
    always @(negedge clk)
    begin
        if (!rst && done.done)
        begin
            if (exp_q.size() == 0)
                abort_run("Completion arrived with no command outstanding");
            got_exp  = exp_q.pop_front();
            got_name = exp_name_q.pop_front();
            check_done(got_name, got_exp.done, done);
            if (got_exp.cmp_rdata)
                check_data(got_name, got_exp.rdata, rdata);
        end
    end

    // ------------------------------
    // Driver
    // ------------------------------
    task automatic drain_pipe(input string why);
        logic empty;
        empty = 1'b0;
        @(negedge clk);
        cmd.req = 1'b0;
        for (int cyc = 0; cyc < TIMEOUT && !empty; cyc++)
        begin
            @(posedge clk);
            empty = exp_q.size() == 0;
        end
        if (!empty)
            abort_run($sformatf("Commands did not complete before %s", why));
    endtask

    task automatic apply_snoop(input bus_pkg::addr_t addr);
        @(negedge clk);
        snoop.hsel      = 1'b1;  // One write by the other master
        snoop.htrans    = bus_pkg::HTRANS_NONSEQ;
        snoop.hwrite    = 1'b1;
        snoop.haddr     = addr;
        snoop.hready    = 1'b1;
        snoop.hreadyout = 1'b1;
    endtask

    task automatic send_command(input string name, input bus_pkg::cmd_kind_e kind,
                                input bus_pkg::size_t size, input bus_pkg::addr_t addr,
                                input bus_pkg::data_t wdata, input bus_pkg::data_t exp_rdata,
                                input bus_pkg::bus_done_t exp_done);
        expect_t e;
        logic    taken;
        taken = 1'b0;
        @(negedge clk);
        cmd.req       = 1'b1;
        cmd.kind      = kind;
        cmd.size      = size;
        cmd.addr      = addr;
        cmd.wdata     = wdata;
        snoop.hsel    = 1'b0;
        snoop.htrans  = bus_pkg::HTRANS_IDLE;
        for (int cyc = 0; cyc < TIMEOUT && !taken; cyc++)
        begin
            @(posedge clk);
            taken = ack;
        end
        if (!taken)
            abort_run($sformatf("Command %s was not accepted in %0d cycles", name, TIMEOUT));
        e.rdata     = exp_rdata;
        e.done      = exp_done;
        e.cmp_rdata = kind != bus_pkg::WRITE && !exp_done.exception && !exp_done.buserr;
        exp_q.push_back(e);
        exp_name_q.push_back(name);
        // Misaligned and failed SC stay off the bus
        if (!exp_done.exception && !(kind == bus_pkg::SC && exp_rdata == bus_pkg::SC_FAIL_VALUE))
        begin
            haddr_q.push_back(addr);
            haddr_name_q.push_back(name);
        end
    endtask

    initial
    begin
        int unsigned seed_ret;
        int          fd;
        int          fields;
        logic        released;
        string       line;
        string       name;
        logic [31:0] v_snp;
        logic [31:0] v_snp_addr;
        logic [31:0] v_kind;
        logic [31:0] v_size;
        logic [31:0] v_addr;
        logic [31:0] v_wdata;
        logic [31:0] v_rdata;
        logic [31:0] v_done;
        cmd      = '0;
        snoop    = '0;
        released = 1'b0;
        seed_ret = $urandom(RAND_SEED);
        for (int i = 0; i < 256; i++)
            wait_tab[i] = $urandom % 4;  // 0 to 3 wait states

        for (int cyc = 0; cyc < TIMEOUT && !released; cyc++)
        begin
            @(posedge clk);
            released = !rst;
        end
        if (!released)
            abort_run("Reset was never released");
        @(negedge clk);
        check_done("reset", '0, done);
        if (ack || ahb_m.hsel || ahb_m.htrans != bus_pkg::HTRANS_IDLE)
            abort_run("Bus port outputs active after reset");

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0)
            abort_run("Cannot open the vector file");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %s", v_snp, v_snp_addr, v_kind,
                             v_size, v_addr, v_wdata, v_rdata, v_done, name);
            if (fields != 9)
                abort_run($sformatf("Malformed vector line: %s", line));
            if (v_snp[0])
            begin
                drain_pipe(name);           // Reservation settled first
                apply_snoop(v_snp_addr);
            end
            send_command(name, bus_pkg::cmd_kind_e'(v_kind[1:0]), v_size[1:0], v_addr,
                         v_wdata, v_rdata, v_done[3:0]);
        end
        $fclose(fd);

        drain_pipe("the end of the run");
        if (haddr_q.size() != 0)
        begin
            abort_run("Expected AHB transfers never appeared");
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: testbench/tb_clock_gen.sv
/* Testbench clock and reset */
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;                // Held for three rising edges
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    always #50 clk = ~clk;         // Period 100

endmodule

// File: rtl/hart_bus_port.sv
/* Hart AHB bus port */
module hart_bus_port #(
    parameter int RESV_GRANULE_LOG2 = 2  // Reservation granule, log2 bytes
) (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::bus_cmd_t   cmd,
    output logic                ack,
    output bus_pkg::bus_done_t  done,
    output bus_pkg::data_t      rdata,
    output bus_pkg::ahb_m_req_t ahb_m,
    input  bus_pkg::ahb_m_rsp_t ahb_rsp,
    input  bus_pkg::ahb_snoop_t snoop  // Second port, monitor only
);

    // ------------------------------
    // Stage links
    // ------------------------------
    bus_pkg::pipe_item_t cs_item;  // Command stage out
    bus_pkg::pipe_item_t ap_item;  // Address phase out
    bus_pkg::ahb_m_req_t ap_bus;
    bus_pkg::data_t      hwdata;
    bus_pkg::addr_t      lr_addr;
    logic                cs_valid;
    logic                ap_valid;
    logic                advance;
    logic                hready;
    logic                resv_hit;
    logic                sc_issue;
    logic                lr_done;
    logic                dp_busy;
    logic                pipe_busy;

    assign pipe_busy = ap_valid || dp_busy;

    always_comb
    begin
        ahb_m        = ap_bus;
        ahb_m.hwdata = hwdata;  // Write data from data phase
    end

    bus_cmd_stage u_cmd_stage (
        .clk(clk), .rst(rst),
        .cmd(cmd), .ack(ack),
        .resv_hit(resv_hit), .pipe_busy(pipe_busy), .advance(advance),
        .item(cs_item), .item_valid(cs_valid), .sc_issue(sc_issue)
    );

    lrsc_monitor #(
        .RESV_GRANULE_LOG2(RESV_GRANULE_LOG2)
    ) u_lrsc_monitor (
        .clk(clk), .rst(rst),
        .snoop(snoop), .chk_addr(cmd.addr), .resv_hit(resv_hit),
        .lr_done(lr_done), .lr_addr(lr_addr), .sc_issue(sc_issue)
    );

    ahb_addr_phase u_addr_phase (
        .clk(clk), .rst(rst),
        .item_in(cs_item), .valid_in(cs_valid), .advance(advance),
        .ahb_hready(hready), .ahb_out(ap_bus),
        .item_out(ap_item), .valid_out(ap_valid)
    );

    ahb_data_phase u_data_phase (
        .clk(clk), .rst(rst),
        .item_in(ap_item), .valid_in(ap_valid), .rsp(ahb_rsp),
        .hwdata(hwdata), .hready(hready), .done(done), .rdata(rdata),
        .lr_done(lr_done), .lr_addr(lr_addr), .busy(dp_busy)
    );

endmodule

// File: rtl/ahb_data_phase.sv
/* AHB data phase and completion */
module ahb_data_phase (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::pipe_item_t item_in,
    input  logic                valid_in,
    input  bus_pkg::ahb_m_rsp_t rsp,
    output bus_pkg::data_t      hwdata,
    output logic                hready,   // Ready seen by address phase
    output bus_pkg::bus_done_t  done,
    output bus_pkg::data_t      rdata,
    output logic                lr_done,
    output bus_pkg::addr_t      lr_addr,
    output logic                busy
);

    bus_pkg::pipe_item_t dp_item;
    bus_pkg::pipe_item_t fin_item;  // Item completing this edge
    logic                dp_valid;
    logic                dp_on_bus;
    logic                bus_done;     // Transfer ends on hreadyout
    logic                held_done;    // Parked non-bus item ends
    logic                direct_done;  // Non-bus item ends straight from address phase
    logic                fin;
    logic                fin_write;

    // ------------------------------
    // Completion select
    // ------------------------------
    assign dp_on_bus   = dp_valid && dp_item.on_bus;
    assign hready      = !dp_on_bus || rsp.hreadyout;
    assign bus_done    = dp_on_bus && rsp.hreadyout;
    assign held_done   = dp_valid && !dp_item.on_bus;
    assign direct_done = valid_in && !item_in.on_bus && !dp_valid;

    assign fin_item  = dp_valid ? dp_item : item_in;  // Older item first
    assign fin       = bus_done || held_done || direct_done;
    assign fin_write = fin_item.kind == bus_pkg::WRITE || fin_item.kind == bus_pkg::SC;

    assign hwdata  = dp_item.wdata;
    assign busy    = dp_valid;
    assign lr_done = bus_done && dp_item.kind == bus_pkg::LR && !rsp.hresp;
    assign lr_addr = dp_item.addr;

    // ------------------------------
    // Data phase register
    // ------------------------------
    // A non-bus item only parks here when an older item leaves on the same edge
    always_ff @(posedge clk)
    begin
        if (rst)
            dp_valid <= 1'b0;
        else if (hready)
            dp_valid <= valid_in && (item_in.on_bus || dp_valid);
    end

    always_ff @(posedge clk)
    begin
        if (hready)
            dp_item <= item_in;
    end

    // ------------------------------
    // Done and read data
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done <= '0;
        end
        else
        begin
            done.done      <= fin;
            done.write     <= bus_done && fin_write;  // Failed SC never writes
            done.buserr    <= bus_done && rsp.hresp;
            done.exception <= fin && fin_item.exception;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus_done)
            rdata <= (dp_item.kind == bus_pkg::SC) ? bus_pkg::SC_OK_VALUE : rsp.hrdata;
        else if (fin)
            rdata <= fin_item.sc_fail ? bus_pkg::SC_FAIL_VALUE : '0;
    end

endmodule

// File: rtl/ahb_addr_phase.sv
/* AHB address phase */
module ahb_addr_phase (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::pipe_item_t item_in,
    input  logic                valid_in,
    output logic                advance,     // Taking item_in this edge
    input  logic                ahb_hready,
    output bus_pkg::ahb_m_req_t ahb_out,
    output bus_pkg::pipe_item_t item_out,
    output logic                valid_out
);

    logic on_bus;  // Real transfer in address phase

    // Address phase may only move on a ready bus
    assign advance = !valid_out || ahb_hready;

    // ------------------------------
    // Phase register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_out <= 1'b0;
        end
        else if (advance)
        begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            item_out <= item_in;  // Held through wait states
        end
    end

    // ------------------------------
    // AHB address outputs
    // ------------------------------
    assign on_bus = valid_out && item_out.on_bus;

    always_comb
    begin
        ahb_out.hsel   = on_bus;
        ahb_out.htrans = on_bus ? bus_pkg::HTRANS_NONSEQ : bus_pkg::HTRANS_IDLE;
        ahb_out.hwrite = on_bus
                      && (item_out.kind == bus_pkg::WRITE || item_out.kind == bus_pkg::SC);
        ahb_out.hsize  = {1'b0, item_out.size};
        ahb_out.haddr  = item_out.addr;
        ahb_out.hwdata = '0;  // Data lags by a phase
    end

endmodule

// File: rtl/lrsc_monitor.sv
/* LR/SC reservation monitor */
module lrsc_monitor #(
    parameter int RESV_GRANULE_LOG2 = 2  // log2 of granule bytes
) (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::ahb_snoop_t snoop,
    input  bus_pkg::addr_t      chk_addr,  // Address of incoming command
    output logic                resv_hit,
    input  logic                lr_done,   // LR completed without error
    input  bus_pkg::addr_t      lr_addr,
    input  logic                sc_issue
);

    localparam int MSB = $bits(bus_pkg::addr_t) - 1;

    logic           snoop_wr;
    logic           snoop_hit_resv;
    logic           snoop_hit_lr;
    logic           resv_valid;
    bus_pkg::addr_t resv_addr;

    // ------------------------------
    // Snoop decode
    // ------------------------------
    assign snoop_wr = snoop.hsel && snoop.htrans[1] && snoop.hready
                   && snoop.hreadyout && snoop.hwrite;  // Accepted write by another master

    assign snoop_hit_resv = snoop_wr
        && snoop.haddr[MSB:RESV_GRANULE_LOG2] == resv_addr[MSB:RESV_GRANULE_LOG2];
    assign snoop_hit_lr = snoop_wr
        && snoop.haddr[MSB:RESV_GRANULE_LOG2] == lr_addr[MSB:RESV_GRANULE_LOG2];

    // Same-cycle snoop write already counts against the SC
    assign resv_hit = resv_valid && !snoop_hit_resv
        && chk_addr[MSB:RESV_GRANULE_LOG2] == resv_addr[MSB:RESV_GRANULE_LOG2];

    // ------------------------------
    // Reservation
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            resv_valid <= 1'b0;
        else if (sc_issue)
            resv_valid <= 1'b0;           // Any SC consumes it
        else if (lr_done)
            resv_valid <= !snoop_hit_lr;  // New granule, lost if written now
        else if (snoop_hit_resv)
            resv_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (lr_done)
            resv_addr <= lr_addr;
    end

endmodule

// File: rtl/bus_cmd_stage.sv
/* Command accept stage */
module bus_cmd_stage (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::bus_cmd_t   cmd,
    output logic                ack,
    input  logic                resv_hit,    // SC address still reserved
    input  logic                pipe_busy,   // Address or data phase occupied
    input  logic                advance,     // Address phase takes our item
    output bus_pkg::pipe_item_t item,
    output logic                item_valid,
    output logic                sc_issue     // SC accepted, drop reservation
);

    logic                misaligned;
    logic                is_sc;
    logic                sc_fail;
    logic                slot_free;
    bus_pkg::pipe_item_t item_next;

    // ------------------------------
    // Command decode
    // ------------------------------
    assign misaligned = (cmd.size == 2'd1 && cmd.addr[0])            // Odd halfword
                     || (cmd.size == 2'd2 && cmd.addr[1:0] != 2'b00) // Unaligned word
                     || (cmd.size == 2'd3);                          // No such size

    assign is_sc   = cmd.kind == bus_pkg::SC;
    assign sc_fail = is_sc && !misaligned && !resv_hit;  // Judged at accept

    // An SC waits for an empty pipe so that older LRs have settled the reservation
    assign slot_free = !item_valid || advance;
    assign ack       = cmd.req && slot_free && !(is_sc && (item_valid || pipe_busy));
    assign sc_issue  = ack && is_sc;

    always_comb
    begin
        item_next.kind      = cmd.kind;
        item_next.size      = cmd.size;
        item_next.addr      = cmd.addr;
        item_next.wdata     = cmd.wdata;
        item_next.exception = misaligned;
        item_next.sc_fail   = sc_fail;
        item_next.on_bus    = !misaligned && !sc_fail;  // Only clean commands go out
    end

    // ------------------------------
    // Item register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            item_valid <= 1'b0;
        end
        else if (ack)
        begin
            item_valid <= 1'b1;  // New item, may replace a departing one
        end
        else if (advance)
        begin
            item_valid <= 1'b0;  // Handed on, nothing behind
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack)
        begin
            item <= item_next;
        end
    end

endmodule

// File: rtl/bus_pkg.sv
/* Hart bus port types */
package bus_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    typedef logic [31:0] addr_t;  // Byte address
    typedef logic [31:0] data_t;  // Bus data word
    typedef logic [1:0]  size_t;  // 0 byte, 1 halfword, 2 word

    typedef enum logic [1:0] {
        READ  = 2'd0,  // Plain load
        WRITE = 2'd1,  // Plain store
        LR    = 2'd2,  // Load reserved
        SC    = 2'd3   // Store conditional
    } cmd_kind_e;

    // ------------------------------
    // Core side
    // ------------------------------
    typedef struct packed {
        logic      req;    // Command valid
        cmd_kind_e kind;
        size_t     size;
        addr_t     addr;
        data_t     wdata;
    } bus_cmd_t;

    typedef struct packed {
        logic buserr;     // Slave answered ERROR
        logic exception;  // Misaligned access
        logic write;      // Memory was written
        logic done;       // One pulse per command
    } bus_done_t;

    // ------------------------------
    // AHB side
    // ------------------------------
    typedef struct packed {
        logic       hsel;
        logic [1:0] htrans;
        logic       hwrite;
        logic [2:0] hsize;
        addr_t      haddr;
        data_t      hwdata;
    } ahb_m_req_t;

    typedef struct packed {
        logic  hreadyout;
        data_t hrdata;
        logic  hresp;  // High on ERROR
    } ahb_m_rsp_t;

    typedef struct packed {
        logic       hsel;
        logic [1:0] htrans;
        logic       hwrite;
        addr_t      haddr;
        logic       hready;
        logic       hreadyout;
    } ahb_snoop_t;

    typedef struct packed {
        cmd_kind_e kind;
        size_t     size;
        addr_t     addr;
        data_t     wdata;
        logic      on_bus;     // Needs an AHB transfer
        logic      exception;  // Misaligned, never on bus
        logic      sc_fail;    // SC lost its reservation
    } pipe_item_t;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam data_t SC_FAIL_VALUE = 32'd1;  // Returned by a failed SC
    localparam data_t SC_OK_VALUE   = 32'd0;

endpackage
